// File: logic/bus_pkg.sv
package bus_pkg;

    // ----------------------------------------
    // 64-bit request/response bus geometry
    // ----------------------------------------
    localparam int BUS_ADDR_W = 32;
    localparam int BUS_DATA_W = 64;
    localparam int BUS_STRB_W = 8;

    // Address bit that picks the upper 32-bit half of a bus word
    localparam int HALF_SEL_BIT = 2;

    // Low address bits cleared for word and double word alignment
    localparam int WORD_OFF_W  = 2;
    localparam int DWORD_OFF_W = 3;

    // ----------------------------------------
    // Transfer size codes (log2 of bytes)
    // ----------------------------------------
    typedef enum logic [2:0] {
        SIZE_WORD  = 3'd2,
        SIZE_DWORD = 3'd3
    } size_e;

endpackage

// File: logic/core_port_pkg.sv
package core_port_pkg;

    // Core-side data path
    localparam int WORD_W  = 32;
    localparam int WSTRB_W = 4;

    // Ports merged by the arbiter
    typedef enum logic {
        PORT_DATA  = 1'b0,
        PORT_FETCH = 1'b1
    } port_e;

    // Which port has priority on the next contested grant
    typedef enum logic {
        ARB_FAIR_DATA  = 1'b0,
        ARB_FAIR_FETCH = 1'b1
    } arb_state_e;

    // Ownership queue of outstanding requests
    localparam int OWN_DEPTH = 2;
    localparam int OWN_PTR_W = $clog2(OWN_DEPTH);
    localparam int OWN_CNT_W = $clog2(OWN_DEPTH + 1);

endpackage

// File: logic/wide_bus_if.sv
`timescale 1ns/10ps

interface wide_bus_if;

    // Request channel
    logic                           q_valid;
    logic                           q_ready;
    logic [bus_pkg::BUS_ADDR_W-1:0] q_addr;
    logic                           q_write;
    logic [bus_pkg::BUS_DATA_W-1:0] q_data;
    logic [bus_pkg::BUS_STRB_W-1:0] q_strb;
    bus_pkg::size_e                 q_size;

    // Response channel
    logic                           p_valid;
    logic                           p_ready;
    logic [bus_pkg::BUS_DATA_W-1:0] p_data;
    logic                           p_error;

    modport master (
        output q_valid, q_addr, q_write, q_data, q_strb, q_size,
        input  q_ready,
        input  p_valid, p_data, p_error,
        output p_ready
    );

    modport slave (
        input  q_valid, q_addr, q_write, q_data, q_strb, q_size,
        output q_ready,
        output p_valid, p_data, p_error,
        input  p_ready
    );

endinterface

// File: logic/fetch_bridge.sv
`timescale 1ns/10ps

module fetch_bridge (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             fetch_req_i,
    input  logic [bus_pkg::BUS_ADDR_W-1:0]   fetch_addr_i,
    output logic                             fetch_ack_o,
    output logic [core_port_pkg::WORD_W-1:0] fetch_rdata_o,
    wide_bus_if.master                       bus
);

    logic                           q_valid_q;
    logic                           pending_q;
    logic [bus_pkg::BUS_ADDR_W-1:0] q_addr_q;
    logic                           half_sel_q;
    logic                           q_fire;
    logic                           p_fire;

    assign q_fire = bus.q_valid & bus.q_ready;
    assign p_fire = bus.p_valid & bus.p_ready;

    // ----------------------------------------
    // Request side
    // ----------------------------------------

    // Single outstanding fetch, set on request transfer
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else if (q_fire) begin
            pending_q <= 1'b1;
        end else if (p_fire) begin
            pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            q_valid_q <= 1'b0;
        end else if (q_fire || pending_q) begin
            q_valid_q <= 1'b0;
        end else if (fetch_req_i) begin
            q_valid_q <= 1'b1;
        end
    end

    // Capture only while idle so the payload holds during a stall
    always_ff @(posedge clk_i) begin
        if (fetch_req_i && !q_valid_q && !pending_q) begin
            q_addr_q   <= {fetch_addr_i[bus_pkg::BUS_ADDR_W-1:bus_pkg::DWORD_OFF_W],
                           {bus_pkg::DWORD_OFF_W{1'b0}}};
            half_sel_q <= fetch_addr_i[bus_pkg::HALF_SEL_BIT];
        end
    end

    // Always a full double word read
    assign bus.q_valid = q_valid_q;
    assign bus.q_addr  = q_addr_q;
    assign bus.q_write = 1'b0;
    assign bus.q_data  = '0;
    assign bus.q_strb  = '1;
    assign bus.q_size  = bus_pkg::SIZE_DWORD;

    // ----------------------------------------
    // Response side
    // ----------------------------------------
    assign bus.p_ready   = 1'b1;
    assign fetch_ack_o   = p_fire;
    assign fetch_rdata_o = half_sel_q ? bus.p_data[bus_pkg::BUS_DATA_W-1:core_port_pkg::WORD_W]
                                      : bus.p_data[core_port_pkg::WORD_W-1:0];

    // No new request goes out while the previous fetch is unanswered
    a_no_req_while_pending : assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(bus.q_valid && pending_q));

endmodule

// File: logic/load_store_bridge.sv
`timescale 1ns/10ps

module load_store_bridge (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              data_req_i,
    input  logic                              data_we_i,
    input  logic [bus_pkg::BUS_ADDR_W-1:0]    data_addr_i,
    input  logic [core_port_pkg::WORD_W-1:0]  data_wdata_i,
    input  logic [core_port_pkg::WSTRB_W-1:0] data_strb_i,
    output logic                              data_ack_o,
    output logic [core_port_pkg::WORD_W-1:0]  data_rdata_o,
    output logic                              data_error_o,
    wide_bus_if.master                        bus
);

    logic pending_q;
    logic half_sel_q;
    logic upper_half;
    logic q_fire;
    logic p_fire;

    assign upper_half = data_addr_i[bus_pkg::HALF_SEL_BIT];
    assign q_fire     = bus.q_valid & bus.q_ready;
    assign p_fire     = bus.p_valid & bus.p_ready;

    // Blocks a repeat of the held request until its response
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else if (q_fire) begin
            pending_q <= 1'b1;
        end else if (p_fire) begin
            pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (q_fire) begin
            half_sel_q <= upper_half;
        end
    end

    // ----------------------------------------
    // Request with lane placement
    // ----------------------------------------
    assign bus.q_valid = data_req_i & ~pending_q;
    assign bus.q_addr  = {data_addr_i[bus_pkg::BUS_ADDR_W-1:bus_pkg::WORD_OFF_W],
                          {bus_pkg::WORD_OFF_W{1'b0}}};
    assign bus.q_write = data_we_i;
    assign bus.q_size  = bus_pkg::SIZE_WORD;
    assign bus.q_strb  = upper_half ? {data_strb_i, {core_port_pkg::WSTRB_W{1'b0}}}
                                    : {{core_port_pkg::WSTRB_W{1'b0}}, data_strb_i};
    assign bus.q_data  = upper_half ? {data_wdata_i, {core_port_pkg::WORD_W{1'b0}}}
                                    : {{core_port_pkg::WORD_W{1'b0}}, data_wdata_i};

    // Response
    assign bus.p_ready    = data_req_i;
    assign data_ack_o     = p_fire;
    assign data_error_o   = p_fire & bus.p_error;
    assign data_rdata_o   = half_sel_q ? bus.p_data[bus_pkg::BUS_DATA_W-1:core_port_pkg::WORD_W]
                                       : bus.p_data[core_port_pkg::WORD_W-1:0];

    // Core must hold its address while the bus stalls the request
    a_addr_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (bus.q_valid && !bus.q_ready) |=> $stable(bus.q_addr));

endmodule

// File: logic/bus_arbiter.sv
`timescale 1ns/10ps

module bus_arbiter (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    wide_bus_if.slave                      fetch_bus,
    wide_bus_if.slave                      data_bus,
    output logic                           bus_q_valid_o,
    input  logic                           bus_q_ready_i,
    output logic [bus_pkg::BUS_ADDR_W-1:0] bus_q_addr_o,
    output logic                           bus_q_write_o,
    output logic [bus_pkg::BUS_DATA_W-1:0] bus_q_data_o,
    output logic [bus_pkg::BUS_STRB_W-1:0] bus_q_strb_o,
    output bus_pkg::size_e                 bus_q_size_o,
    input  logic                           bus_p_valid_i,
    output logic                           bus_p_ready_o,
    input  logic [bus_pkg::BUS_DATA_W-1:0] bus_p_data_i,
    input  logic                           bus_p_error_i
);

    core_port_pkg::arb_state_e           arb_state_q;
    core_port_pkg::port_e                sel_port;
    core_port_pkg::port_e                lock_port_q;
    core_port_pkg::port_e                own_q [core_port_pkg::OWN_DEPTH];
    core_port_pkg::port_e                head;
    logic                                lock_q;
    logic [core_port_pkg::OWN_PTR_W-1:0] wr_ptr_q;
    logic [core_port_pkg::OWN_PTR_W-1:0] rd_ptr_q;
    logic [core_port_pkg::OWN_CNT_W-1:0] count_q;
    logic                                room;
    logic                                owed;
    logic                                q_fire;
    logic                                p_fire;

    assign room   = (count_q != core_port_pkg::OWN_DEPTH);
    assign owed   = (count_q != '0);
    assign head   = own_q[rd_ptr_q];
    assign q_fire = bus_q_valid_o & bus_q_ready_i;
    assign p_fire = bus_p_valid_i & bus_p_ready_o;

    // ----------------------------------------
    // Request grant
    // ----------------------------------------

    // A stalled grant stays locked to its port until it transfers
    always_comb begin
        if (lock_q) begin
            sel_port = lock_port_q;
        end else if (fetch_bus.q_valid && data_bus.q_valid) begin
            if (arb_state_q == core_port_pkg::ARB_FAIR_FETCH) begin
                sel_port = core_port_pkg::PORT_FETCH;
            end else begin
                sel_port = core_port_pkg::PORT_DATA;
            end
        end else if (fetch_bus.q_valid) begin
            sel_port = core_port_pkg::PORT_FETCH;
        end else begin
            sel_port = core_port_pkg::PORT_DATA;
        end
    end

    always_comb begin
        if (sel_port == core_port_pkg::PORT_FETCH) begin
            bus_q_valid_o = room & fetch_bus.q_valid;
            bus_q_addr_o  = fetch_bus.q_addr;
            bus_q_write_o = fetch_bus.q_write;
            bus_q_data_o  = fetch_bus.q_data;
            bus_q_strb_o  = fetch_bus.q_strb;
            bus_q_size_o  = fetch_bus.q_size;
        end else begin
            bus_q_valid_o = room & data_bus.q_valid;
            bus_q_addr_o  = data_bus.q_addr;
            bus_q_write_o = data_bus.q_write;
            bus_q_data_o  = data_bus.q_data;
            bus_q_strb_o  = data_bus.q_strb;
            bus_q_size_o  = data_bus.q_size;
        end
    end

    assign fetch_bus.q_ready = room & bus_q_ready_i & (sel_port == core_port_pkg::PORT_FETCH);
    assign data_bus.q_ready  = room & bus_q_ready_i & (sel_port == core_port_pkg::PORT_DATA);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            arb_state_q <= core_port_pkg::ARB_FAIR_DATA;
            lock_q      <= 1'b0;
            lock_port_q <= core_port_pkg::PORT_DATA;
        end else begin
            lock_q      <= bus_q_valid_o & ~bus_q_ready_i;
            lock_port_q <= sel_port;
            // Winner hands priority to the other port
            if (q_fire) begin
                if (sel_port == core_port_pkg::PORT_FETCH) begin
                    arb_state_q <= core_port_pkg::ARB_FAIR_DATA;
                end else begin
                    arb_state_q <= core_port_pkg::ARB_FAIR_FETCH;
                end
            end
        end
    end

    // ----------------------------------------
    // Ownership queue
    // ----------------------------------------

    // Depth is a power of two so pointers wrap on their own
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (q_fire) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (p_fire) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({q_fire, p_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (q_fire) begin
            own_q[wr_ptr_q] <= sel_port;
        end
    end

    // Responses go to the owner at the head of the queue
    assign fetch_bus.p_valid = bus_p_valid_i & owed & (head == core_port_pkg::PORT_FETCH);
    assign data_bus.p_valid  = bus_p_valid_i & owed & (head == core_port_pkg::PORT_DATA);
    assign fetch_bus.p_data  = bus_p_data_i;
    assign data_bus.p_data   = bus_p_data_i;
    assign fetch_bus.p_error = bus_p_error_i;
    assign data_bus.p_error  = bus_p_error_i;
    assign bus_p_ready_o     = owed & ((head == core_port_pkg::PORT_FETCH) ? fetch_bus.p_ready
                                                                           : data_bus.p_ready);

    a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
        q_fire |-> (count_q != core_port_pkg::OWN_DEPTH));

    a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
        p_fire |-> (count_q != '0));

    a_valid_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (bus_q_valid_o && !bus_q_ready_i) |=> bus_q_valid_o);

endmodule

// File: logic/ext_mem_bridge_top.sv
`timescale 1ns/10ps

module ext_mem_bridge_top (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    // Instruction fetch port
    input  logic                              fetch_req_i,
    input  logic [bus_pkg::BUS_ADDR_W-1:0]    fetch_addr_i,
    output logic                              fetch_ack_o,
    output logic [core_port_pkg::WORD_W-1:0]  fetch_rdata_o,
    // Load/store port
    input  logic                              data_req_i,
    input  logic                              data_we_i,
    input  logic [bus_pkg::BUS_ADDR_W-1:0]    data_addr_i,
    input  logic [core_port_pkg::WORD_W-1:0]  data_wdata_i,
    input  logic [core_port_pkg::WSTRB_W-1:0] data_strb_i,
    output logic                              data_ack_o,
    output logic [core_port_pkg::WORD_W-1:0]  data_rdata_o,
    output logic                              data_error_o,
    // 64-bit request/response bus
    output logic                              bus_q_valid_o,
    input  logic                              bus_q_ready_i,
    output logic [bus_pkg::BUS_ADDR_W-1:0]    bus_q_addr_o,
    output logic                              bus_q_write_o,
    output logic [bus_pkg::BUS_DATA_W-1:0]    bus_q_data_o,
    output logic [bus_pkg::BUS_STRB_W-1:0]    bus_q_strb_o,
    output bus_pkg::size_e                    bus_q_size_o,
    input  logic                              bus_p_valid_i,
    output logic                              bus_p_ready_o,
    input  logic [bus_pkg::BUS_DATA_W-1:0]    bus_p_data_i,
    input  logic                              bus_p_error_i
);

    wide_bus_if fetch_bus ();
    wide_bus_if data_bus ();

    // ----------------------------------------
    // Core-side bridges
    // ----------------------------------------
    fetch_bridge u_fetch_bridge (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_ack_o   (fetch_ack_o),
        .fetch_rdata_o (fetch_rdata_o),
        .bus           (fetch_bus.master)
    );

    load_store_bridge u_load_store_bridge (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .data_req_i   (data_req_i),
        .data_we_i    (data_we_i),
        .data_addr_i  (data_addr_i),
        .data_wdata_i (data_wdata_i),
        .data_strb_i  (data_strb_i),
        .data_ack_o   (data_ack_o),
        .data_rdata_o (data_rdata_o),
        .data_error_o (data_error_o),
        .bus          (data_bus.master)
    );

    // ----------------------------------------
    // Merge onto the external bus
    // ----------------------------------------
    bus_arbiter u_bus_arbiter (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .fetch_bus     (fetch_bus.slave),
        .data_bus      (data_bus.slave),
        .bus_q_valid_o (bus_q_valid_o),
        .bus_q_ready_i (bus_q_ready_i),
        .bus_q_addr_o  (bus_q_addr_o),
        .bus_q_write_o (bus_q_write_o),
        .bus_q_data_o  (bus_q_data_o),
        .bus_q_strb_o  (bus_q_strb_o),
        .bus_q_size_o  (bus_q_size_o),
        .bus_p_valid_i (bus_p_valid_i),
        .bus_p_ready_o (bus_p_ready_o),
        .bus_p_data_i  (bus_p_data_i),
        .bus_p_error_i (bus_p_error_i)
    );

endmodule

// File: bench/bus_memory_model.sv
`timescale 1ns/10ps

module bus_memory_model (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           q_valid_i,
    output logic                           q_ready_o,
    input  logic [bus_pkg::BUS_ADDR_W-1:0] q_addr_i,
    input  logic                           q_write_i,
    input  logic [bus_pkg::BUS_DATA_W-1:0] q_data_i,
    input  logic [bus_pkg::BUS_STRB_W-1:0] q_strb_i,
    output logic                           p_valid_o,
    input  logic                           p_ready_i,
    output logic [bus_pkg::BUS_DATA_W-1:0] p_data_o,
    output logic                           p_error_o
);

    logic [31:0] lcg_q;
    logic [7:0]  mem [int unsigned];
    logic [63:0] data_q [$];
    logic        err_q [$];
    int          dly_q [$];

    // One LCG step
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Unwritten bytes read back as a mix of all address bits
    function automatic logic [7:0] pattern_byte(input logic [31:0] addr);
        return addr[31:24] ^ addr[23:16] ^ addr[15:8] ^ addr[7:0] ^ 8'hA5;
    endfunction

    always @(posedge clk_i or negedge rst_ni) begin : model_proc
        logic [31:0] rnd;
        logic [31:0] base;
        logic [63:0] rdata;
        if (!rst_ni) begin
            lcg_q     <= 32'd35;
            q_ready_o <= 1'b0;
            p_valid_o <= 1'b0;
            p_data_o  <= '0;
            p_error_o <= 1'b0;
            data_q.delete();
            err_q.delete();
            dly_q.delete();
        end else begin
            rnd = lcg_next(lcg_q);
            lcg_q <= rnd;
            // ----------------------------------------
            // Accept a request, write lanes, then read back
            // ----------------------------------------
            if (q_valid_i && q_ready_o) begin
                base = {q_addr_i[31:3], 3'b000};
                for (int i = 0; i < 8; i++) begin
                    if (q_write_i && q_strb_i[i]) begin
                        mem[base + 32'(i)] = q_data_i[8*i +: 8];
                    end
                    rdata[8*i +: 8] = mem.exists(base + 32'(i)) ? mem[base + 32'(i)]
                                                                : pattern_byte(base + 32'(i));
                end
                data_q.push_back(rdata);
                err_q.push_back(q_addr_i[31:12] == 20'h0000F);
                dly_q.push_back(int'(rnd[17:16]));
            end
            if (p_valid_o && p_ready_i) begin
                data_q.pop_front();
                err_q.pop_front();
                dly_q.pop_front();
            end
            // Head response shows up once its delay has run out
            if (dly_q.size() > 0 && dly_q[0] == 0) begin
                p_valid_o <= 1'b1;
                p_data_o  <= data_q[0];
                p_error_o <= err_q[0];
            end else begin
                p_valid_o <= 1'b0;
                if (dly_q.size() > 0) begin
                    dly_q[0] = dly_q[0] - 1;
                end
            end
            q_ready_o <= (rnd[21:20] != 2'b00);
        end
    end

endmodule

// File: bench/tb_ext_mem_bridge.sv
`timescale 1ns/10ps

module tb_ext_mem_bridge;

    localparam int WAIT_LIMIT = 64;

    logic           clk;
    logic           rst_n;
    logic           rst_d;
    logic           fetch_req;
    logic [31:0]    fetch_addr;
    logic           fetch_ack;
    logic [31:0]    fetch_rdata;
    logic           data_req;
    logic           data_we;
    logic [31:0]    data_addr;
    logic [31:0]    data_wdata;
    logic [3:0]     data_strb;
    logic           data_ack;
    logic [31:0]    data_rdata;
    logic           data_error;
    logic           bus_q_valid;
    logic           bus_q_ready;
    logic [31:0]    bus_q_addr;
    logic           bus_q_write;
    logic [63:0]    bus_q_data;
    logic [7:0]     bus_q_strb;
    bus_pkg::size_e bus_q_size;
    logic           bus_p_valid;
    logic           bus_p_ready;
    logic [63:0]    bus_p_data;
    logic           bus_p_error;

    // Expected values of the outstanding accesses
    logic           fetch_busy;
    logic [31:0]    exp_fetch_addr;
    logic [31:0]    exp_fetch_rdata;
    logic           data_busy;
    logic [31:0]    exp_q_addr;
    logic [7:0]     exp_q_strb;
    logic [63:0]    exp_q_data;
    logic [31:0]    exp_data_rdata;
    logic           exp_data_error;
    logic [7:0]     shadow [int unsigned];
    int             in_flight;

    always #20 clk = ~clk;

    ext_mem_bridge_top u_dut (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .fetch_req_i   (fetch_req),
        .fetch_addr_i  (fetch_addr),
        .fetch_ack_o   (fetch_ack),
        .fetch_rdata_o (fetch_rdata),
        .data_req_i    (data_req),
        .data_we_i     (data_we),
        .data_addr_i   (data_addr),
        .data_wdata_i  (data_wdata),
        .data_strb_i   (data_strb),
        .data_ack_o    (data_ack),
        .data_rdata_o  (data_rdata),
        .data_error_o  (data_error),
        .bus_q_valid_o (bus_q_valid),
        .bus_q_ready_i (bus_q_ready),
        .bus_q_addr_o  (bus_q_addr),
        .bus_q_write_o (bus_q_write),
        .bus_q_data_o  (bus_q_data),
        .bus_q_strb_o  (bus_q_strb),
        .bus_q_size_o  (bus_q_size),
        .bus_p_valid_i (bus_p_valid),
        .bus_p_ready_o (bus_p_ready),
        .bus_p_data_i  (bus_p_data),
        .bus_p_error_i (bus_p_error)
    );

    bus_memory_model u_mem (
        .clk_i     (clk),
        .rst_ni    (rst_n),
        .q_valid_i (bus_q_valid),
        .q_ready_o (bus_q_ready),
        .q_addr_i  (bus_q_addr),
        .q_write_i (bus_q_write),
        .q_data_i  (bus_q_data),
        .q_strb_i  (bus_q_strb),
        .p_valid_o (bus_p_valid),
        .p_ready_i (bus_p_ready),
        .p_data_o  (bus_p_data),
        .p_error_o (bus_p_error)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    function automatic logic [7:0] pattern_byte(input logic [31:0] addr);
        return addr[31:24] ^ addr[23:16] ^ addr[15:8] ^ addr[7:0] ^ 8'hA5;
    endfunction

    // Word at a 4-byte aligned address as memory should hold it
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] base;
        logic [31:0] word;
        base = {addr[31:2], 2'b00};
        for (int i = 0; i < 4; i++) begin
            word[8*i +: 8] = shadow.exists(base + 32'(i)) ? shadow[base + 32'(i)]
                                                          : pattern_byte(base + 32'(i));
        end
        return word;
    endfunction

    // ----------------------------------------
    // Bookkeeping
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_d     <= 1'b0;
            in_flight <= 0;
        end else begin
            rst_d     <= 1'b1;
            in_flight <= in_flight + int'(bus_q_valid && bus_q_ready)
                                   - int'(bus_p_valid && bus_p_ready);
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_reset_quiet : assert property (@(posedge clk)
        (!rst_n || !rst_d) |-> (!bus_q_valid && !fetch_ack && !data_ack))
        else report_failure($sformatf(
            "[ERROR] in reset bus_q_valid_o/fetch_ack_o/data_ack_o expected 0 got %h/%h/%h",
            $sampled(bus_q_valid), $sampled(fetch_ack), $sampled(data_ack)));

    a_fetch_req : assert property (@(posedge clk) disable iff (!rst_n)
        (bus_q_valid && bus_q_size == bus_pkg::SIZE_DWORD) |-> (fetch_busy && !bus_q_write
            && bus_q_strb == 8'hFF && bus_q_addr == exp_fetch_addr))
        else report_failure($sformatf(
            "[ERROR] fetch bus_q_addr_o expected %h got %h, bus_q_strb_o %h, bus_q_write_o %h",
            exp_fetch_addr, $sampled(bus_q_addr), $sampled(bus_q_strb), $sampled(bus_q_write)));

    a_data_req : assert property (@(posedge clk) disable iff (!rst_n)
        (bus_q_valid && bus_q_size != bus_pkg::SIZE_DWORD) |-> (data_busy
            && bus_q_size == bus_pkg::SIZE_WORD && bus_q_addr == exp_q_addr
            && bus_q_strb == exp_q_strb && bus_q_write == data_we
            && (!data_we || bus_q_data == exp_q_data)))
        else report_failure($sformatf(
            "[ERROR] data bus_q_addr_o %h/%h bus_q_strb_o %h/%h bus_q_data_o %h/%h (exp/got)",
            exp_q_addr, $sampled(bus_q_addr), exp_q_strb, $sampled(bus_q_strb),
            exp_q_data, $sampled(bus_q_data)));

    a_fetch_data : assert property (@(posedge clk) disable iff (!rst_n)
        fetch_ack |-> (fetch_busy && fetch_rdata == exp_fetch_rdata))
        else report_failure($sformatf("[ERROR] fetch_rdata_o expected %h got %h",
            exp_fetch_rdata, $sampled(fetch_rdata)));

    a_load_data : assert property (@(posedge clk) disable iff (!rst_n)
        (data_ack && !data_we) |-> (data_rdata == exp_data_rdata))
        else report_failure($sformatf("[ERROR] data_rdata_o expected %h got %h",
            exp_data_rdata, $sampled(data_rdata)));

    a_data_error : assert property (@(posedge clk) disable iff (!rst_n)
        data_ack |-> (data_busy && data_error == exp_data_error))
        else report_failure($sformatf("[ERROR] data_error_o expected %h got %h",
            exp_data_error, $sampled(data_error)));

    a_error_idle : assert property (@(posedge clk) disable iff (!rst_n)
        !data_ack |-> !data_error)
        else report_failure($sformatf("[ERROR] data_error_o expected 0 got %h",
            $sampled(data_error)));

    a_in_flight : assert property (@(posedge clk) disable iff (!rst_n)
        in_flight <= 2)
        else report_failure($sformatf("[ERROR] in_flight expected at most 2 got %h",
            $sampled(in_flight)));

    // Both ports stay ready while a response is owed to them
    a_resp_ready : assert property (@(posedge clk) disable iff (!rst_n)
        bus_p_ready == (in_flight != 0))
        else report_failure($sformatf("[ERROR] bus_p_ready_o expected %h got %h",
            $sampled(in_flight) != 0, $sampled(bus_p_ready)));

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic fetch_word(input logic [31:0] addr);
        int cycles;
        @(negedge clk);
        exp_fetch_addr  = {addr[31:3], 3'b000};
        exp_fetch_rdata = expected_word(addr);
        fetch_busy      = 1'b1;
        fetch_addr      = addr;
        fetch_req       = 1'b1;
        @(negedge clk);
        fetch_req = 1'b0;
        cycles    = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_failure("Timeout while waiting for a fetch acknowledge");
            end
        end while (!fetch_ack);
        @(negedge clk);
        fetch_busy = 1'b0;
    endtask

    task automatic data_access(input logic we, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] strb);
        int cycles;
        @(negedge clk);
        exp_q_addr     = {addr[31:2], 2'b00};
        exp_q_strb     = addr[2] ? {strb, 4'h0} : {4'h0, strb};
        exp_q_data     = addr[2] ? {wdata, 32'h0} : {32'h0, wdata};
        exp_data_rdata = expected_word(addr);
        exp_data_error = (addr[31:12] == 20'h0000F);
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) begin
                    shadow[exp_q_addr + 32'(i)] = wdata[8*i +: 8];
                end
            end
        end
        data_busy  = 1'b1;
        data_we    = we;
        data_addr  = addr;
        data_wdata = wdata;
        data_strb  = strb;
        data_req   = 1'b1;
        cycles     = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_failure("Timeout while waiting for a load/store acknowledge");
            end
        end while (!data_ack);
        // Request stays up through the transfer edge
        @(negedge clk);
        data_req  = 1'b0;
        data_busy = 1'b0;
    endtask

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b1;
        fetch_req       = 1'b0;
        fetch_addr      = '0;
        data_req        = 1'b0;
        data_we         = 1'b0;
        data_addr       = '0;
        data_wdata      = '0;
        data_strb       = '0;
        fetch_busy      = 1'b0;
        data_busy       = 1'b0;
        exp_fetch_addr  = '0;
        exp_fetch_rdata = '0;
        exp_q_addr      = '0;
        exp_q_strb      = '0;
        exp_q_data      = '0;
        exp_data_rdata  = '0;
        exp_data_error  = 1'b0;
        // Falling reset edge before the first clock edge
        #1;
        rst_n = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        // Fetches on their own, both halves
        for (int i = 0; i < 6; i++) begin
            fetch_word(32'h0000_1000 + 32'(i) * 4 + 32'(i % 2));
        end

        // Stores with partial strobes, then loads back
        data_access(1'b1, 32'h0000_2000, 32'hDEAD_BEEF, 4'hF);
        data_access(1'b1, 32'h0000_2004, 32'h1234_5678, 4'b0101);
        data_access(1'b0, 32'h0000_2000, 32'h0, 4'hF);
        data_access(1'b0, 32'h0000_2004, 32'h0, 4'hF);
        data_access(1'b0, 32'h0000_2010, 32'h0, 4'hF);

        // Both ports at once
        fork
            begin
                for (int i = 0; i < 10; i++) begin
                    fetch_word(32'h0000_1100 + 32'(i) * 12);
                end
            end
            begin
                for (int i = 0; i < 8; i++) begin
                    data_access(1'b1, 32'h0000_2040 + 32'(i) * 4, {16'hC0DE, 16'(i)},
                                4'(i * 5 + 1));
                    data_access(1'b0, 32'h0000_2040 + 32'(i) * 4, 32'h0, 4'hF);
                end
            end
        join

        // Error region, then normal access again
        data_access(1'b0, 32'h0000_F008, 32'h0, 4'hF);
        data_access(1'b1, 32'h0000_F00C, 32'hA5A5_5A5A, 4'hF);
        data_access(1'b0, 32'h0000_F00C, 32'h0, 4'hF);
        data_access(1'b0, 32'h0000_2004, 32'h0, 4'hF);

        repeat (2) @(negedge clk);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: verilog.f
logic/bus_pkg.sv
logic/core_port_pkg.sv
logic/wide_bus_if.sv
logic/fetch_bridge.sv
logic/load_store_bridge.sv
logic/bus_arbiter.sv
logic/ext_mem_bridge_top.sv
bench/bus_memory_model.sv
bench/tb_ext_mem_bridge.sv

// File: Bender.yml
package:
  name: ext_mem_bridge

sources:
  # Packages first, then the interface and the RTL
  - logic/bus_pkg.sv
  - logic/core_port_pkg.sv
  - logic/wide_bus_if.sv
  - logic/fetch_bridge.sv
  - logic/load_store_bridge.sv
  - logic/bus_arbiter.sv
  - logic/ext_mem_bridge_top.sv

  # Simulation only
  - target: test
    files:
      - bench/bus_memory_model.sv
      - bench/tb_ext_mem_bridge.sv
